// ==== isa_pkg.sv ====
package isa_pkg;

	localparam int PC_W  = 32;
	localparam int OPC_W = 7;

	typedef logic [PC_W-1:0]  pc_t;      // instruction address.
	typedef logic [OPC_W-1:0] opcode_t;  // major opcode field, inst[6:0].

	// major opcodes of the base integer isa that the monitor follows.
	localparam opcode_t OPC_LOAD  = 7'b0000011;
	localparam opcode_t OPC_STORE = 7'b0100011;

endpackage

// ==== rm_pkg.sv ====
package rm_pkg;

	localparam int NUM_LANES  = 4;
	localparam int NUM_EVENTS = 6;  // last stage is the commit leaf.
	localparam int NUM_RULES  = 4;
	localparam int NUM_ITYPES = 2;
	localparam int LANE_W     = $clog2(NUM_LANES);

	// chain stage index of each event.
	localparam int EV_DECODE  = 0;
	localparam int EV_ISSUE   = 1;
	localparam int EV_AGEN    = 2;
	localparam int EV_MEM_REQ = 3;
	localparam int EV_MEM_RSP = 4;
	localparam int EV_COMMIT  = 5;

	typedef logic [LANE_W-1:0]     lane_id_t;
	typedef logic                  ins_type_t;
	typedef logic [NUM_EVENTS-1:0] event_vec_t;
	typedef logic [NUM_LANES-1:0]  lane_mask_t;
	typedef logic [NUM_RULES-1:0]  rule_vec_t;
	typedef logic [NUM_ITYPES-1:0] itype_mask_t;  // bit i set applies to type i.

	localparam ins_type_t ITYPE_LOAD  = 1'b0;
	localparam ins_type_t ITYPE_STORE = 1'b1;

	// token that walks the event chain.
	typedef struct packed {
		logic      valid;
		lane_id_t  lane;
		ins_type_t itype;
	} lane_ctrl_t;

	// what one stage saw this cycle.
	typedef struct packed {
		logic      present;
		logic      hit;
		logic      flushed;
		lane_id_t  lane;
		ins_type_t itype;
	} stage_rec_t;

	typedef struct packed {
		logic        valid;
		lane_id_t    lane;
		ins_type_t   itype;
		rule_vec_t   rules;
		isa_pkg::pc_t pc;
	} violation_t;

	// r0 issue seen, r1 load got a response, r2 store got none, r3 commit seen.
	localparam itype_mask_t RULE_APPLIES [NUM_RULES] = '{
		2'b11,
		2'b01,
		2'b10,
		2'b11
	};
	localparam event_vec_t RULE_REQUIRED [NUM_RULES] = '{
		event_vec_t'(1 << EV_ISSUE),
		event_vec_t'(1 << EV_MEM_RSP),
		event_vec_t'(0),
		event_vec_t'(1 << EV_COMMIT)
	};
	localparam event_vec_t RULE_FORBIDDEN [NUM_RULES] = '{
		event_vec_t'(0),
		event_vec_t'(0),
		event_vec_t'(1 << EV_MEM_RSP),
		event_vec_t'(0)
	};

endpackage

// ==== rm_lane_allocator.sv ====
`timescale 1ns/10ps

module rm_lane_allocator (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               entry_queued_i,
	input  isa_pkg::opcode_t   opcode_i,
	input  isa_pkg::pc_t       pc_i,
	input  rm_pkg::lane_mask_t release_i,
	output rm_pkg::lane_ctrl_t token_o,
	output isa_pkg::pc_t       lane_pc_o [rm_pkg::NUM_LANES],
	output logic               dropped_o
);

	rm_pkg::lane_mask_t busy_q;
	rm_pkg::lane_mask_t alloc_mask;
	rm_pkg::lane_id_t   free_lane;
	logic               free_found;
	logic               is_load;
	logic               is_store;
	logic               monitored;
	logic               dropped_q;
	isa_pkg::pc_t       lane_pc_q [rm_pkg::NUM_LANES];

	assign is_load   = (opcode_i == isa_pkg::OPC_LOAD);
	assign is_store  = (opcode_i == isa_pkg::OPC_STORE);
	assign monitored = entry_queued_i && (is_load || is_store);

	// lowest free lane, looking at the registered busy mask only.
	always_comb begin
		free_found = 1'b0;
		free_lane  = '0;
		for (int l = 0; l < rm_pkg::NUM_LANES; l++) begin
			if (!busy_q[l] && !free_found) begin
				free_found = 1'b1;
				free_lane  = rm_pkg::lane_id_t'(l);
			end
		end
	end

	assign token_o.valid = monitored && free_found;
	assign token_o.lane  = free_lane;
	assign token_o.itype = is_store ? rm_pkg::ITYPE_STORE : rm_pkg::ITYPE_LOAD;

	assign alloc_mask = token_o.valid ? (rm_pkg::lane_mask_t'(1) << free_lane) : '0;

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			busy_q    <= '0;
			dropped_q <= 1'b0;
		end else begin
			busy_q    <= (busy_q & ~release_i) | alloc_mask;
			dropped_q <= monitored && !free_found;  // all lanes taken.
		end
	end

	always_ff @(posedge clk_i) begin
		if (token_o.valid) begin
			lane_pc_q[free_lane] <= pc_i;
		end
	end

	assign lane_pc_o = lane_pc_q;
	assign dropped_o = dropped_q;

endmodule

// ==== rm_event_detector.sv ====
`timescale 1ns/10ps

module rm_event_detector (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  rm_pkg::lane_ctrl_t token_i,
	input  logic               event_i,
	input  logic               flush_i,
	output rm_pkg::lane_ctrl_t token_o,
	output rm_pkg::stage_rec_t rec_o
);

	rm_pkg::lane_ctrl_t token_q;

	// one stage per cycle, so the token is always taken from upstream.
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			token_q <= '0;
		end else begin
			token_q <= token_i;
		end
	end

	always_comb begin
		rec_o.present = token_q.valid;
		rec_o.hit     = token_q.valid && event_i;
		rec_o.flushed = token_q.valid && flush_i;
		rec_o.lane    = token_q.lane;
		rec_o.itype   = token_q.itype;
	end

	// a flushed token dies here.
	always_comb begin
		token_o       = token_q;
		token_o.valid = token_q.valid && !flush_i;
	end

endmodule

// ==== rm_event_router.sv ====
`timescale 1ns/10ps

module rm_event_router (
	input  rm_pkg::stage_rec_t recs_i [rm_pkg::NUM_EVENTS],
	output rm_pkg::event_vec_t lane_set_o [rm_pkg::NUM_LANES],
	output rm_pkg::lane_mask_t lane_release_o,
	output rm_pkg::lane_ctrl_t complete_o
);

	localparam int LEAF = rm_pkg::NUM_EVENTS - 1;

	always_comb begin
		lane_release_o = '0;
		for (int l = 0; l < rm_pkg::NUM_LANES; l++) begin
			lane_set_o[l] = '0;
		end
		for (int k = 0; k < rm_pkg::NUM_EVENTS; k++) begin
			if (recs_i[k].present) begin
				if (recs_i[k].hit && !recs_i[k].flushed) begin
					lane_set_o[recs_i[k].lane][k] = 1'b1;
				end
				if (recs_i[k].flushed || k == LEAF) begin
					lane_release_o[recs_i[k].lane] = 1'b1;  // squash or leaf exit.
				end
			end
		end
	end

	assign complete_o.valid = recs_i[LEAF].present && !recs_i[LEAF].flushed;
	assign complete_o.lane  = recs_i[LEAF].lane;
	assign complete_o.itype = recs_i[LEAF].itype;

endmodule

// ==== rm_monitor.sv ====
`timescale 1ns/10ps

module rm_monitor (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  rm_pkg::event_vec_t lane_set_i [rm_pkg::NUM_LANES],
	input  rm_pkg::lane_mask_t lane_release_i,
	input  rm_pkg::lane_ctrl_t complete_i,
	input  isa_pkg::pc_t       lane_pc_i [rm_pkg::NUM_LANES],
	output rm_pkg::violation_t violation_o
);

	rm_pkg::event_vec_t lane_ev_q [rm_pkg::NUM_LANES];
	rm_pkg::event_vec_t final_ev;
	rm_pkg::rule_vec_t  rule_fail;
	logic               fail_any;

	logic               viol_valid_q;
	rm_pkg::lane_id_t   viol_lane_q;
	rm_pkg::ins_type_t  viol_itype_q;
	rm_pkg::rule_vec_t  viol_rules_q;
	isa_pkg::pc_t       viol_pc_q;

	// per-lane event history, wiped when the lane is given back.
	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			for (int l = 0; l < rm_pkg::NUM_LANES; l++) begin
				lane_ev_q[l] <= '0;
			end
		end else begin
			for (int l = 0; l < rm_pkg::NUM_LANES; l++) begin
				if (lane_release_i[l]) begin
					lane_ev_q[l] <= '0;
				end else begin
					lane_ev_q[l] <= lane_ev_q[l] | lane_set_i[l];
				end
			end
		end
	end

	// the leaf hit lands in the same cycle as completion.
	assign final_ev = lane_ev_q[complete_i.lane] | lane_set_i[complete_i.lane];

	always_comb begin
		for (int r = 0; r < rm_pkg::NUM_RULES; r++) begin
			rule_fail[r] = rm_pkg::RULE_APPLIES[r][complete_i.itype] &&
				(((rm_pkg::RULE_REQUIRED[r] & ~final_ev) != '0) ||
				 ((rm_pkg::RULE_FORBIDDEN[r] & final_ev) != '0));
		end
	end

	assign fail_any = complete_i.valid && (rule_fail != '0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			viol_valid_q <= 1'b0;
		end else begin
			viol_valid_q <= fail_any;  // one-cycle pulse.
		end
	end

	always_ff @(posedge clk_i) begin
		if (fail_any) begin
			viol_lane_q  <= complete_i.lane;
			viol_itype_q <= complete_i.itype;
			viol_rules_q <= rule_fail;
			viol_pc_q    <= lane_pc_i[complete_i.lane];
		end
	end

	assign violation_o = '{
		valid: viol_valid_q,
		lane:  viol_lane_q,
		itype: viol_itype_q,
		rules: viol_rules_q,
		pc:    viol_pc_q
	};

endmodule

// ==== rm_top.sv ====
`timescale 1ns/10ps

module rm_top (
	input  logic               clk_i,
	input  logic               rst_ni,
	input  logic               entry_queued_i,
	input  isa_pkg::opcode_t   opcode_i,
	input  isa_pkg::pc_t       pc_i,
	input  rm_pkg::event_vec_t event_i,
	input  rm_pkg::event_vec_t flush_i,
	output rm_pkg::violation_t violation_o,
	output logic               dropped_o
);

	localparam int LEAF = rm_pkg::NUM_EVENTS - 1;

	rm_pkg::lane_ctrl_t alloc_token;
	rm_pkg::lane_ctrl_t stage_token [LEAF];  // stage k to stage k+1.
	rm_pkg::stage_rec_t recs [rm_pkg::NUM_EVENTS];
	rm_pkg::event_vec_t lane_set [rm_pkg::NUM_LANES];
	rm_pkg::lane_mask_t lane_release;
	rm_pkg::lane_ctrl_t complete;
	isa_pkg::pc_t       lane_pc [rm_pkg::NUM_LANES];

	rm_lane_allocator u_alloc (
		.clk_i,
		.rst_ni,
		.entry_queued_i,
		.opcode_i,
		.pc_i,
		.release_i (lane_release),
		.token_o   (alloc_token),
		.lane_pc_o (lane_pc),
		.dropped_o
	);

	for (genvar k = 0; k < rm_pkg::NUM_EVENTS; k++) begin : g_stage
		if (k == 0) begin : g_head
			rm_event_detector u_det (
				.clk_i,
				.rst_ni,
				.token_i (alloc_token),
				.event_i (event_i[k]),
				.flush_i (flush_i[k]),
				.token_o (stage_token[k]),
				.rec_o   (recs[k])
			);
		end else if (k < LEAF) begin : g_mid
			rm_event_detector u_det (
				.clk_i,
				.rst_ni,
				.token_i (stage_token[k-1]),
				.event_i (event_i[k]),
				.flush_i (flush_i[k]),
				.token_o (stage_token[k]),
				.rec_o   (recs[k])
			);
		end else begin : g_leaf
			// commit stage, the router retires its token.
			rm_event_detector u_det (
				.clk_i,
				.rst_ni,
				.token_i (stage_token[k-1]),
				.event_i (event_i[k]),
				.flush_i (flush_i[k]),
				.token_o (),
				.rec_o   (recs[k])
			);
		end
	end

	rm_event_router u_router (
		.recs_i         (recs),
		.lane_set_o     (lane_set),
		.lane_release_o (lane_release),
		.complete_o     (complete)
	);

	rm_monitor u_monitor (
		.clk_i,
		.rst_ni,
		.lane_set_i     (lane_set),
		.lane_release_i (lane_release),
		.complete_i     (complete),
		.lane_pc_i      (lane_pc),
		.violation_o
	);

endmodule

// ==== rm_assertions.sv ====
`timescale 1ns/10ps

module rm_assertions (
	input logic               clk_i,
	input logic               rst_ni,
	input rm_pkg::lane_ctrl_t token_i,
	input rm_pkg::lane_mask_t busy_i,
	input rm_pkg::lane_mask_t release_i,
	input logic               dropped_i
);

	// a granted lane has to be idle.
	a_token_lane_free: assert property (@(posedge clk_i) disable iff (!rst_ni)
		token_i.valid |-> !busy_i[token_i.lane])
		else $error("token names busy lane %0d", token_i.lane);

	// the drop pulse of a request comes one cycle after it.
	a_no_token_on_drop: assert property (@(posedge clk_i) disable iff (!rst_ni)
		token_i.valid |=> !dropped_i)
		else $error("request got a lane and was also dropped");

	// only the leaf or a flush gives a lane back, and only a held one.
	a_release_busy_only: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(release_i & ~busy_i) == '0)
		else $error("free lane released, mask %b", release_i & ~busy_i);

endmodule

bind rm_lane_allocator rm_assertions rm_assertions_inst (
	.clk_i,
	.rst_ni,
	.token_i   (token_o),
	.busy_i    (busy_q),
	.release_i,
	.dropped_i (dropped_o)
);

// ==== rm_tb.sv ====
`timescale 1ns/10ps

module rm_tb;

	localparam int CLK_PERIOD   = 40;
	localparam int RESET_CYCLES = 16;
	localparam int MAX_CYC      = 32;  // longest schedule any test may use.
	localparam int NUM_TESTS    = 5;
	localparam int WATCHDOG_CYC = RESET_CYCLES + NUM_TESTS * MAX_CYC + 64;
	localparam int NO_FLUSH     = -1;

	// one cycle of stimulus.
	typedef struct packed {
		logic               req;
		isa_pkg::opcode_t   opc;
		isa_pkg::pc_t       pc;
		rm_pkg::event_vec_t ev;
		rm_pkg::event_vec_t fl;
	} stim_t;

	logic               clk_i;
	logic               rst_ni;
	logic               entry_queued_i;
	isa_pkg::opcode_t   opcode_i;
	isa_pkg::pc_t       pc_i;
	rm_pkg::event_vec_t event_i;
	rm_pkg::event_vec_t flush_i;
	rm_pkg::violation_t violation_o;
	logic               dropped_o;

	stim_t              stim [MAX_CYC];
	rm_pkg::violation_t exp_viol [MAX_CYC];
	logic               exp_drop [MAX_CYC];
	int                 lane_free_at [rm_pkg::NUM_LANES];  // first cycle a lane may be taken.
	int                 sched_len;
	logic [31:0]        rng_state = 32'd29118;

	rm_top rm_top_inst (
		.clk_i,
		.rst_ni,
		.entry_queued_i,
		.opcode_i,
		.pc_i,
		.event_i,
		.flush_i,
		.violation_o,
		.dropped_o
	);

	initial begin
		clk_i = 1'b0;
		forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
	end

	initial begin
		#(WATCHDOG_CYC * CLK_PERIOD);
		$display("Timeout: tests still running after %0d cycles", WATCHDOG_CYC);
		$display("Verification failed");
		$fatal(1, "watchdog expired");
	end

	function automatic isa_pkg::pc_t next_pc();
		rng_state = rng_state ^ (rng_state << 13);
		rng_state = rng_state ^ (rng_state >> 17);
		rng_state = rng_state ^ (rng_state << 5);
		return {rng_state[31:2], 2'b00};  // word aligned.
	endfunction

	// r0 issue, r1 load response, r2 no store response, r3 commit.
	function automatic rm_pkg::rule_vec_t expected_rules(input rm_pkg::ins_type_t itype,
			input rm_pkg::event_vec_t seen);
		rm_pkg::rule_vec_t r;
		r[0] = !seen[rm_pkg::EV_ISSUE];
		r[1] = (itype == rm_pkg::ITYPE_LOAD) && !seen[rm_pkg::EV_MEM_RSP];
		r[2] = (itype == rm_pkg::ITYPE_STORE) && seen[rm_pkg::EV_MEM_RSP];
		r[3] = !seen[rm_pkg::EV_COMMIT];
		return r;
	endfunction

	task automatic check(input logic [63:0] actual, input logic [63:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("Error at %0t ns: %s, got %0h, expected %0h", $time, what, actual, expected);
			$display("Verification failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic clear_schedule();
		for (int c = 0; c < MAX_CYC; c++) begin
			stim[c]     = '0;
			exp_viol[c] = '0;
			exp_drop[c] = 1'b0;
		end
		for (int l = 0; l < rm_pkg::NUM_LANES; l++) begin
			lane_free_at[l] = 0;
		end
		sched_len = 0;
	endtask

	// queue a request at cycle t and work out what the monitor must report.
	task automatic add_request(input int t, input isa_pkg::opcode_t opc,
			input rm_pkg::event_vec_t ev, input int flush_at);
		int                 lane;
		rm_pkg::ins_type_t  itype;
		rm_pkg::event_vec_t seen;
		rm_pkg::rule_vec_t  rules;
		lane  = -1;
		itype = (opc == isa_pkg::OPC_STORE) ? rm_pkg::ITYPE_STORE : rm_pkg::ITYPE_LOAD;
		seen  = '0;
		stim[t].req = 1'b1;
		stim[t].opc = opc;
		stim[t].pc  = next_pc();
		if (t + 9 > sched_len) begin
			sched_len = t + 9;
		end
		if (opc == isa_pkg::OPC_LOAD || opc == isa_pkg::OPC_STORE) begin
			for (int l = rm_pkg::NUM_LANES - 1; l >= 0; l--) begin
				if (lane_free_at[l] <= t) begin
					lane = l;  // ends on the lowest free one.
				end
			end
			if (lane < 0) begin
				exp_drop[t + 1] = 1'b1;
			end else begin
				for (int k = 0; k < rm_pkg::NUM_EVENTS; k++) begin
					if (ev[k] && (flush_at == NO_FLUSH || k <= flush_at)) begin
						stim[t + 1 + k].ev[k] = 1'b1;
						seen[k] = 1'b1;
					end
				end
				if (flush_at != NO_FLUSH) begin
					stim[t + 1 + flush_at].fl[flush_at] = 1'b1;
					lane_free_at[lane] = t + 2 + flush_at;
				end else begin
					lane_free_at[lane] = t + 7;
					rules = expected_rules(itype, seen);
					if (rules != '0) begin
						exp_viol[t + 7] = '{valid: 1'b1, lane: rm_pkg::lane_id_t'(lane),
							itype: itype, rules: rules, pc: stim[t].pc};
					end
				end
			end
		end
	endtask

	task automatic run_schedule(input string name);
		for (int c = 0; c < sched_len; c++) begin
			@(posedge clk_i);
			entry_queued_i <= stim[c].req;
			opcode_i       <= stim[c].opc;
			pc_i           <= stim[c].pc;
			event_i        <= stim[c].ev;
			flush_i        <= stim[c].fl;
			@(negedge clk_i);
			check(64'(dropped_o), 64'(exp_drop[c]), $sformatf("%s cycle %0d drop", name, c));
			check(64'(violation_o.valid), 64'(exp_viol[c].valid),
				$sformatf("%s cycle %0d violation valid", name, c));
			if (exp_viol[c].valid) begin
				check(64'(violation_o), 64'(exp_viol[c]),
					$sformatf("%s cycle %0d violation record", name, c));
			end
		end
	endtask

	task automatic reset_and_ignored_opcodes();
		check(64'(violation_o.valid), 64'(0), "violation valid after reset");
		check(64'(dropped_o), 64'(0), "drop after reset");
		clear_schedule();
		add_request(0, 7'b0110011, '1, NO_FLUSH);  // alu op.
		add_request(2, 7'b1100011, '1, NO_FLUSH);  // branch.
		run_schedule("ignored opcodes");
	endtask

	task automatic clean_instructions();
		clear_schedule();
		add_request(0, isa_pkg::OPC_LOAD, 6'b111110, NO_FLUSH);
		add_request(2, isa_pkg::OPC_STORE, 6'b101110, NO_FLUSH);
		run_schedule("clean");
	endtask

	task automatic missing_and_forbidden_events();
		clear_schedule();
		add_request(0, isa_pkg::OPC_LOAD, 6'b101110, NO_FLUSH);   // no response.
		add_request(1, isa_pkg::OPC_STORE, 6'b011110, NO_FLUSH);  // response, no commit.
		run_schedule("missing and forbidden");
	endtask

	task automatic flush_and_reuse();
		clear_schedule();
		add_request(0, isa_pkg::OPC_LOAD, 6'b111110, 3);
		add_request(4, isa_pkg::OPC_STORE, 6'b101100, NO_FLUSH);  // lane 0 still held.
		add_request(5, isa_pkg::OPC_LOAD, 6'b111100, NO_FLUSH);
		run_schedule("flush");
	endtask

	task automatic lane_exhaustion();
		clear_schedule();
		for (int i = 0; i < 5; i++) begin
			add_request(i, isa_pkg::OPC_LOAD, 6'b111100, NO_FLUSH);
		end
		add_request(6, isa_pkg::OPC_LOAD, 6'b111100, NO_FLUSH);  // lane 0 frees at 7.
		add_request(7, isa_pkg::OPC_LOAD, 6'b111100, NO_FLUSH);
		run_schedule("exhaustion");
	endtask

	initial begin
		rst_ni         = 1'b0;
		entry_queued_i = 1'b0;
		opcode_i       = '0;
		pc_i           = '0;
		event_i        = '0;
		flush_i        = '0;
		repeat (RESET_CYCLES) @(posedge clk_i);
		rst_ni <= 1'b1;
		@(negedge clk_i);
		reset_and_ignored_opcodes();
		clean_instructions();
		missing_and_forbidden_events();
		flush_and_reuse();
		lane_exhaustion();
		$display("Verification passed");
		$finish;
	end

endmodule

// ==== runtime_monitor.f ====
isa_pkg.sv
rm_pkg.sv
rm_lane_allocator.sv
rm_event_detector.sv
rm_event_router.sv
rm_monitor.sv
rm_top.sv
rm_assertions.sv
rm_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rm_tb
FILELIST  ?= runtime_monitor.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell cat $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)
